//--- logic/smc_host_pkg.sv
// Host side types of the static memory controller
// Transfer sizes plus the request and response structs
`default_nettype none

package smc_host_pkg;

   // --------------------
   // Transfer size
   // --------------------
   typedef enum logic [1:0] {
      XSIZ_8  = 2'b00,   // Byte
      XSIZ_16 = 2'b01,   // Halfword
      XSIZ_32 = 2'b10    // Word
   } xfer_size_e;

   // --------------------
   // Host request, 68 bits
   // --------------------
   typedef struct packed {
      logic [31:0] addr;    // Byte address
      logic [31:0] wdata;   // Write data on host lanes
      xfer_size_e  size;    // Transfer size
      logic        write;   // 1 for write, 0 for read
      logic        cs;      // Bank select
   } smc_req_t;

   // --------------------
   // Host response, 32 bits
   // --------------------
   // Read word on host lanes, zero after a write
   typedef struct packed {
      logic [31:0] rdata;
   } smc_resp_t;

endpackage

`default_nettype wire

//--- logic/smc_emi_pkg.sv
// Memory side types of the static memory controller
// Bus widths, controller states and the external pin bundle
`default_nettype none

package smc_emi_pkg;

   // External bus width, static per configuration
   typedef enum logic [1:0] {
      BSIZ_8  = 2'b00,   // 8-bit memory
      BSIZ_16 = 2'b01,   // 16-bit memory
      BSIZ_32 = 2'b10    // 32-bit memory
   } bus_size_e;

   // Controller FSM states
   typedef enum logic [1:0] {
      SMC_IDLE = 2'b00,  // Waiting for a request
      SMC_RW   = 2'b01,  // Accesses on the bus
      SMC_RESP = 2'b10   // Response held for the host
   } smc_state_e;

   // Pins driven by the controller, 70 bits
   typedef struct packed {
      logic [31:0] addr;    // Byte address incl. stepped low bits
      logic [3:0]  n_be;    // Byte enables, active low
      logic        n_cs;    // Chip select, active low
      logic        n_we;    // Write enable, active low
      logic [31:0] wdata;   // Write data on memory lanes
   } smc_emi_t;

endpackage

`default_nettype wire

//--- logic/smc_access_ctrl.sv
// Access control FSM of the static memory controller
// Accepts a host request, runs one to four bus accesses with wait
// cycles, then holds the response until the host takes it
`timescale 1ns/1ps
`default_nettype none

module smc_access_ctrl
   import smc_host_pkg::*, smc_emi_pkg::*;
#(
   parameter int unsigned WAIT_CYCLES = 1   // Extra cycles per access
)
(
   input  wire             sys_clk18,
   input  wire             n_sys_reset18,
   input  wire             req_valid,
   input  wire smc_req_t   req,
   input  wire             resp_ready,
   input  wire bus_size_e  bus_size,
   output logic            req_ready,
   output logic            resp_valid,
   output logic            valid_access,   // Accept cycle
   output logic            access_done,    // Access ends, another follows
   output logic [1:0]      num_access,     // Accesses still to follow
   output smc_state_e      next_state,
   output logic            read_capture,   // Sample read lanes
   output logic            n_we            // Registered write enable
);

   localparam logic [2:0] WAIT_LAST = 3'(WAIT_CYCLES);

   smc_state_e  state;
   logic [2:0]  wait_cnt;     // Cycles spent in current access
   logic        write_r;      // Direction stored at accept
   logic        v_write;      // Validated direction
   logic        access_end;   // Last cycle of an access
   logic [1:0]  load_count;   // Accesses after the first

   assign valid_access = req_valid && req_ready;
   assign access_end   = (state == SMC_RW) && (wait_cnt == WAIT_LAST);
   assign access_done  = access_end && (num_access != 2'd0);
   assign read_capture = access_end && !write_r;
   assign v_write      = valid_access ? req.write : write_r;

   // Access count from transfer vs bus width
   always_comb
   begin
      load_count = 2'd0;                            // Single access
      if (req.size == XSIZ_32 && bus_size == BSIZ_8)
         load_count = 2'd3;                         // Four bytes
      else if ((req.size == XSIZ_32 && bus_size == BSIZ_16) ||
               (req.size == XSIZ_16 && bus_size == BSIZ_8))
         load_count = 2'd1;                         // Two halves
   end

   // --------------------
   // Next state
   // --------------------
   always_comb
   begin
      next_state = state;
      case (state)
         SMC_IDLE:
            if (valid_access)
               next_state = SMC_RW;
         SMC_RW:
            if (access_end && num_access == 2'd0)
               next_state = SMC_RESP;               // Last access done
         SMC_RESP:
            if (resp_valid && resp_ready)
               next_state = SMC_IDLE;
         default:
            next_state = SMC_IDLE;
      endcase
   end

   // State, wait and access counters
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
      begin
         state      <= SMC_IDLE;
         wait_cnt   <= 3'd0;
         num_access <= 2'd0;
         write_r    <= 1'b0;
      end
      else
      begin
         state <= next_state;
         if (valid_access)
         begin
            wait_cnt   <= 3'd0;
            num_access <= load_count;
            write_r    <= req.write;
         end
         else if (access_end)
         begin
            wait_cnt <= 3'd0;                       // Next access starts fresh
            if (access_done)
               num_access <= num_access - 2'd1;
         end
         else if (state == SMC_RW)
            wait_cnt <= wait_cnt + 3'd1;
      end
   end

   // --------------------
   // Handshakes and WE
   // --------------------
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
      begin
         req_ready  <= 1'b0;                        // Low until first idle cycle
         resp_valid <= 1'b0;
         n_we       <= 1'b1;
      end
      else
      begin
         req_ready  <= (next_state == SMC_IDLE);
         resp_valid <= (state == SMC_RESP) && !(resp_valid && resp_ready);
         n_we       <= !((next_state == SMC_RW) && v_write);
      end
   end

endmodule

`default_nettype wire

//--- logic/smc_addr.sv
// Address block of the static memory controller
// Registers address and chip select, steps the two low address bits
// between accesses and decodes the byte enables
`timescale 1ns/1ps
`default_nettype none

module smc_addr
   import smc_host_pkg::*, smc_emi_pkg::*;
(
   input  wire              sys_clk18,
   input  wire              n_sys_reset18,
   input  wire              valid_access,   // Accept cycle
   input  wire [1:0]        num_access,     // Accesses still to follow
   input  wire bus_size_e   bus_size,
   input  wire xfer_size_e  xfer_size,      // Live only on accept
   input  wire              cs,
   input  wire [31:0]       addr,
   input  wire              access_done,    // Step to next access
   input  wire smc_state_e  next_state,
   output logic [31:0]      smc_addr,       // EMI address
   output logic [3:0]       smc_n_be,       // EMI byte enables
   output logic             smc_n_cs,       // EMI chip select
   output logic [1:0]       addr_lsb        // Current low bits
);

   logic        r_cs;          // Stored CS
   logic [1:0]  r_addr;        // Stored low address bits
   xfer_size_e  r_xfer_size;   // Stored transfer size
   logic        v_cs;          // Validated copies
   logic [1:0]  v_addr;
   xfer_size_e  v_xfer_size;
   logic [1:0]  first_lsb;     // Low bits of first access
   logic [1:0]  next_lsb;      // Low bits of following access
   logic [3:0]  n_be;          // Unregistered byte enables

   // Live request on accept, stored copy afterwards
   assign v_cs        = valid_access ? cs : r_cs;
   assign v_addr      = valid_access ? addr[1:0] : r_addr;
   assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;
   assign addr_lsb    = smc_addr[1:0];

   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
      begin
         r_cs        <= 1'b0;
         r_addr      <= 2'b00;
         r_xfer_size <= XSIZ_8;
      end
      else if (valid_access)
      begin
         r_cs        <= cs;
         r_addr      <= addr[1:0];
         r_xfer_size <= xfer_size;
      end
   end

   // --------------------
   // Low address bits
   // --------------------
   // Little-endian, highest byte first, counting down to zero
   always_comb
   begin
      case (v_xfer_size)
         XSIZ_32:
            case (bus_size)
               BSIZ_16: first_lsb = 2'b10;          // Upper half first
               BSIZ_8:  first_lsb = 2'b11;          // Byte 3 first
               default: first_lsb = 2'b00;
            endcase
         XSIZ_16:
            first_lsb = {v_addr[1], bus_size == BSIZ_8};
         default:
            first_lsb = v_addr;                     // Byte as addressed
      endcase
   end

   always_comb
   begin
      case ({v_xfer_size, bus_size})
         {XSIZ_32, BSIZ_8}:  next_lsb = num_access - 2'd1;  // 10, 01, 00
         {XSIZ_32, BSIZ_16}: next_lsb = 2'b00;              // Lower half
         {XSIZ_16, BSIZ_8}:  next_lsb = {v_addr[1], 1'b0};  // Lower byte of half
         default:            next_lsb = smc_addr[1:0];
      endcase
   end

   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         smc_addr <= 32'h0;
      else if (valid_access)
         smc_addr <= {addr[31:2], first_lsb};
      else if (access_done)
         smc_addr[1:0] <= next_lsb;                 // Word part holds
   end

   // --------------------
   // Byte enable decode
   // --------------------
   always_comb
   begin
      n_be = 4'b1111;
      if (v_cs)
         case (bus_size)
            BSIZ_8:
               n_be = 4'b1110;                      // Lane 0 only
            BSIZ_16:
               if (v_xfer_size == XSIZ_8)
                  n_be = v_addr[0] ? 4'b1101 : 4'b1110;
               else
                  n_be = 4'b1100;                   // Lanes 1..0
            BSIZ_32:
               case (v_xfer_size)
                  XSIZ_8:  n_be = ~(4'b0001 << v_addr);
                  XSIZ_16: n_be = v_addr[1] ? 4'b0011 : 4'b1100;
                  XSIZ_32: n_be = 4'b0000;
                  default: n_be = 4'b1111;          // Invalid size
               endcase
            default:
               n_be = 4'b1111;
         endcase
   end

   // CS and BE driven only while accesses run
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hf;
      end
      else if (next_state == SMC_RW)
      begin
         smc_n_cs <= ~v_cs;
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hf;
      end
   end

endmodule

`default_nettype wire

//--- logic/smc_data_lane.sv
// Data lane steering of the static memory controller
// Puts host write bytes on the memory lanes of each access and
// gathers read lanes back into the host word
`timescale 1ns/1ps
`default_nettype none

module smc_data_lane
   import smc_emi_pkg::*;
(
   input  wire              sys_clk18,
   input  wire              n_sys_reset18,
   input  wire              valid_access,   // Accept cycle
   input  wire [31:0]       wdata,          // Host lanes, live on accept
   input  wire bus_size_e   bus_size,
   input  wire [1:0]        addr_lsb,       // Low bits of current access
   input  wire              read_capture,   // Last cycle of a read access
   input  wire [31:0]       mem_rdata,
   output logic [31:0]      mem_wdata,      // Memory lanes
   output logic [31:0]      rdata           // Assembled read word
);

   logic [31:0] wdata_r;   // Write word held for all accesses
   logic [15:0] wr_half;   // Host half for 16-bit bus
   logic [7:0]  wr_byte;   // Host byte for 8-bit bus

   // --------------------
   // Write path
   // --------------------
   always_ff @(posedge sys_clk18)
   begin
      if (valid_access)
         wdata_r <= wdata;
   end

   // Host byte k goes to lane k mod bus bytes
   assign wr_half = addr_lsb[1] ? wdata_r[31:16] : wdata_r[15:0];
   assign wr_byte = wdata_r[{addr_lsb, 3'b000} +: 8];

   always_comb
   begin
      case (bus_size)
         BSIZ_8:
            mem_wdata = {4{wr_byte}};               // Byte copied on all lanes
         BSIZ_16:
            mem_wdata = {2{wr_half}};
         default:
            mem_wdata = wdata_r;                    // Straight through
      endcase
   end

   // --------------------
   // Read path
   // --------------------
   // Cleared at accept, so a write answers zero
   always_ff @(posedge sys_clk18 or negedge n_sys_reset18)
   begin
      if (!n_sys_reset18)
         rdata <= 32'h0;
      else if (valid_access)
         rdata <= 32'h0;
      else if (read_capture)
      begin
         case (bus_size)
            BSIZ_8:
               rdata[{addr_lsb, 3'b000} +: 8] <= mem_rdata[7:0];
            BSIZ_16:
               rdata[{addr_lsb[1], 4'b0000} +: 16] <= mem_rdata[15:0];
            default:
               rdata <= mem_rdata;                  // Whole word in one go
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/smc_lite.sv
// Static memory controller top level, single bank
// Host valid/ready request and response, fixed-latency memory pins
`timescale 1ns/1ps
`default_nettype none

module smc_lite
   import smc_host_pkg::*, smc_emi_pkg::*;
#(
   parameter int unsigned WAIT_CYCLES = 1   // Extra cycles per access, 0..7
)
(
   input  wire             sys_clk18,
   input  wire             n_sys_reset18,
   input  wire bus_size_e  bus_size,        // Static configuration
   input  wire             req_valid,
   input  wire smc_req_t   req,
   input  wire             resp_ready,
   input  wire [31:0]      mem_rdata,
   output logic            req_ready,
   output logic            resp_valid,
   output smc_resp_t       resp,
   output smc_emi_t        emi
);

   logic        valid_access;
   logic        access_done;
   logic        read_capture;
   logic        n_we;
   logic [1:0]  num_access;
   logic [1:0]  addr_lsb;
   smc_state_e  next_state;
   logic [31:0] emi_addr;
   logic [3:0]  emi_n_be;
   logic        emi_n_cs;
   logic [31:0] mem_wdata;
   logic [31:0] rdata;

   // --------------------
   // Output packing
   // --------------------
   assign emi = '{addr: emi_addr, n_be: emi_n_be, n_cs: emi_n_cs,
                  n_we: n_we, wdata: mem_wdata};
   assign resp = '{rdata: rdata};

   smc_access_ctrl #(.WAIT_CYCLES(WAIT_CYCLES)) u_ctrl (
      .sys_clk18(sys_clk18), .n_sys_reset18(n_sys_reset18),
      .req_valid(req_valid), .req(req), .resp_ready(resp_ready),
      .bus_size(bus_size), .req_ready(req_ready), .resp_valid(resp_valid),
      .valid_access(valid_access), .access_done(access_done),
      .num_access(num_access), .next_state(next_state),
      .read_capture(read_capture), .n_we(n_we)
   );

   smc_addr u_addr (
      .sys_clk18(sys_clk18), .n_sys_reset18(n_sys_reset18),
      .valid_access(valid_access), .num_access(num_access),
      .bus_size(bus_size), .xfer_size(req.size), .cs(req.cs),
      .addr(req.addr), .access_done(access_done), .next_state(next_state),
      .smc_addr(emi_addr), .smc_n_be(emi_n_be), .smc_n_cs(emi_n_cs),
      .addr_lsb(addr_lsb)
   );

   smc_data_lane u_lane (
      .sys_clk18(sys_clk18), .n_sys_reset18(n_sys_reset18),
      .valid_access(valid_access), .wdata(req.wdata), .bus_size(bus_size),
      .addr_lsb(addr_lsb), .read_capture(read_capture),
      .mem_rdata(mem_rdata), .mem_wdata(mem_wdata), .rdata(rdata)
   );

endmodule

`default_nettype wire

//--- dv/smc_clock_gen.sv
// Testbench clock and reset for the static memory controller
// 10 ns clock, active-low reset held for 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module smc_clock_gen #(
   parameter int HALF_PERIOD  = 5,   // ns
   parameter int RESET_CYCLES = 8
)
(
   output logic sys_clk18,
   output logic n_sys_reset18
);

   initial
   begin
      sys_clk18 = 1'b0;
      forever #HALF_PERIOD sys_clk18 = ~sys_clk18;
   end

   initial
   begin
      n_sys_reset18 = 1'b0;                         // Reset from time zero
      repeat (RESET_CYCLES) @(posedge sys_clk18);
      #1 n_sys_reset18 = 1'b1;                      // Release off the edge
   end

endmodule

`default_nettype wire

//--- dv/smc_mem_model.sv
// Behavioral memory for the static memory controller testbench
// Byte array on the emi pins, with a log of every bus access
`timescale 1ns/1ps
`default_nettype none

module smc_mem_model
   import smc_emi_pkg::*;
(
   input  wire             sys_clk18,
   input  wire bus_size_e  bus_size,
   input  wire smc_emi_t   emi,
   output logic [31:0]     mem_rdata
);

   logic [7:0]  mem [0:255];            // Low 256 bytes of the bank
   logic [35:0] access_log [$];         // {addr, n_be} per access
   logic [7:0]  base;                   // Byte address of lane 0
   logic        prev_n_cs = 1'b1;
   logic [31:0] prev_addr = 32'h0;

   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[i] = 8'(i) ^ 8'h5a;        // Fill follows the whole address
   end

   // Lane 0 sits on the bus-aligned address
   always_comb
   begin
      base = emi.addr[7:0];
      if (bus_size == BSIZ_16)
         base[0] = 1'b0;
      else if (bus_size == BSIZ_32)
         base[1:0] = 2'b00;
   end

   // Only enabled lanes answer, the rest read zero
   always_comb
   begin
      mem_rdata = 32'h0;
      for (int j = 0; j < 4; j++)
         if (!emi.n_cs && !emi.n_be[j])
            mem_rdata[8*j +: 8] = mem[base + 8'(j)];
   end

   // --------------------
   // Writes and access log
   // --------------------
   always @(posedge sys_clk18)
   begin
      if (!emi.n_cs && (prev_n_cs || emi.addr != prev_addr))
         access_log.push_back({emi.addr, emi.n_be});   // New access
      if (!emi.n_cs && !emi.n_we)
         for (int j = 0; j < 4; j++)
            if (!emi.n_be[j])
               mem[base + 8'(j)] = emi.wdata[8*j +: 8];
      prev_n_cs = emi.n_cs;
      prev_addr = emi.addr;
   end

   function automatic logic [7:0] peek_byte(input logic [31:0] a);
      return mem[a[7:0]];
   endfunction

   function automatic int log_size();
      return access_log.size();
   endfunction

   function automatic logic [35:0] log_entry(input int i);
      return access_log[i];
   endfunction

   task automatic clear_log();
      access_log.delete();
   endtask

endmodule

`default_nettype wire

//--- dv/smc_lite_tb.sv
// Directed testbench of the static memory controller
// Word, halfword and byte transfers over 8, 16 and 32 bit buses
`timescale 1ns/1ps
`default_nettype none

module smc_lite_tb
   import smc_host_pkg::*, smc_emi_pkg::*;
();

   localparam int WAIT_N     = 2;       // DUT wait cycles per access
   localparam int MAX_CYCLES = 2000;    // Tests need roughly 300

   logic        sys_clk18;
   logic        n_sys_reset18;
   bus_size_e   bus_size;
   logic        req_valid;
   smc_req_t    req;
   logic        resp_ready;
   logic [31:0] mem_rdata;
   logic        req_ready;
   logic        resp_valid;
   smc_resp_t   resp;
   smc_emi_t    emi;
   int          cycles = 0;
   int          seed = 32'hc873;

   smc_clock_gen u_clk (.sys_clk18(sys_clk18), .n_sys_reset18(n_sys_reset18));

   smc_lite #(.WAIT_CYCLES(WAIT_N)) DUT (
      .sys_clk18(sys_clk18), .n_sys_reset18(n_sys_reset18), .bus_size(bus_size),
      .req_valid(req_valid), .req(req), .resp_ready(resp_ready),
      .mem_rdata(mem_rdata), .req_ready(req_ready), .resp_valid(resp_valid),
      .resp(resp), .emi(emi)
   );

   smc_mem_model u_mem (
      .sys_clk18(sys_clk18), .bus_size(bus_size), .emi(emi), .mem_rdata(mem_rdata)
   );

   // Run limit
   always @(posedge sys_clk18)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("STATUS: FAIL");
         $fatal(1, "Timeout, tests still running after %0d cycles", MAX_CYCLES);
      end
   end

   task automatic step_cycle();
      @(posedge sys_clk18);
      #1;                                           // Drive and sample off the edge
   endtask

   task automatic compare(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // --------------------
   // Expected values
   // --------------------
   function automatic int accesses_for(input xfer_size_e size, input bus_size_e bus);
      if (size == XSIZ_32 && bus == BSIZ_8)
         return 4;
      if ((size == XSIZ_32 && bus == BSIZ_16) || (size == XSIZ_16 && bus == BSIZ_8))
         return 2;
      return 1;
   endfunction

   // Low bits of access i from the highest byte down
   function automatic logic [1:0] lsb_for(input xfer_size_e size, input bus_size_e bus,
                                          input logic [1:0] a, input int i);
      if (size == XSIZ_32 && bus == BSIZ_8)
         return 2'(3 - i);
      if (size == XSIZ_32 && bus == BSIZ_16)
         return (i == 0) ? 2'b10 : 2'b00;
      if (size == XSIZ_32)
         return 2'b00;
      if (size == XSIZ_16)
         return {a[1], bus == BSIZ_8 && i == 0};
      return a;                                     // Byte as addressed
   endfunction

   function automatic logic [3:0] be_for(input xfer_size_e size, input bus_size_e bus,
                                         input logic [1:0] a);
      logic [31:0] mask;
      mask = lane_mask(size, a);
      case (bus)
         BSIZ_8:  return 4'b1110;
         BSIZ_16: return (size != XSIZ_8) ? 4'b1100 : (a[0] ? 4'b1101 : 4'b1110);
         default: return ~{mask[24], mask[16], mask[8], mask[0]};   // Covered lanes
      endcase
   endfunction

   // Host lanes a transfer covers
   function automatic logic [31:0] lane_mask(input xfer_size_e size, input logic [1:0] a);
      case (size)
         XSIZ_8:  return 32'hff << (8 * a);
         XSIZ_16: return a[1] ? 32'hffff_0000 : 32'h0000_ffff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   // --------------------
   // Transfers
   // --------------------
   task automatic run_xfer(input logic write, input xfer_size_e size,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input int hold, output logic [31:0] rdata);
      int          lat;
      int          n;
      logic [35:0] entry;
      logic [31:0] mask;
      n    = accesses_for(size, bus_size);
      mask = lane_mask(size, addr[1:0]);
      u_mem.clear_log();
      req = '{addr: addr, wdata: wdata, size: size, write: write, cs: 1'b1};
      req_valid = 1'b1;
      while (!req_ready)
         step_cycle();
      step_cycle();                                 // Accept edge
      req_valid = 1'b0;
      lat = 0;
      while (!resp_valid)
      begin
         step_cycle();
         lat++;
      end
      compare("latency", lat, n * (WAIT_N + 1) + 1);
      rdata = resp.rdata;
      if (hold > 0)
         req_valid = 1'b1;                          // Next request waits behind the stall
      repeat (hold)
      begin
         step_cycle();
         compare("resp_valid in stall", 32'(resp_valid), 1);
         compare("resp in stall", resp.rdata, rdata);
         compare("req_ready in stall", 32'(req_ready), 0);
         compare("n_cs in stall", 32'(emi.n_cs), 1);
         compare("n_be in stall", 32'(emi.n_be), 32'hf);
      end
      resp_ready = 1'b1;
      step_cycle();                                 // Response handshake
      resp_ready = 1'b0;
      req_valid  = 1'b0;
      compare("resp_valid after handshake", 32'(resp_valid), 0);
      compare("req_ready after handshake", 32'(req_ready), 1);
      compare("access count", u_mem.log_size(), n);
      for (int i = 0; i < n; i++)
      begin
         entry = u_mem.log_entry(i);
         compare("access address", entry[35:4],
                 {addr[31:2], lsb_for(size, bus_size, addr[1:0], i)});
         compare("byte enables", 32'(entry[3:0]), 32'(be_for(size, bus_size, addr[1:0])));
      end
      if (write)
         for (int k = 0; k < 4; k++)
            if (mask[8*k])
               compare("stored byte", 32'(u_mem.peek_byte({addr[31:2], 2'(k)})),
                       32'(wdata[8*k +: 8]));
   endtask

   task automatic write_read(input xfer_size_e size, input logic [31:0] addr,
                             input int hold);
      logic [31:0] data;
      logic [31:0] got;
      data = $random(seed);
      run_xfer(1'b1, size, addr, data, 0, got);
      compare("write response", got, 32'h0);
      run_xfer(1'b0, size, addr, ~data, hold, got);   // Stray write would show
      compare("read data", got, data & lane_mask(size, addr[1:0]));
   endtask

   // --------------------
   // Directed tests
   // --------------------
   task automatic idle_pins();
      compare("req_ready", 32'(req_ready), 0);
      compare("resp_valid", 32'(resp_valid), 0);
      compare("emi n_cs", 32'(emi.n_cs), 1);
      compare("emi n_we", 32'(emi.n_we), 1);
      compare("emi n_be", 32'(emi.n_be), 32'hf);
      compare("emi addr", emi.addr, 32'h0);
   endtask

   task automatic reset_state();
      step_cycle();
      step_cycle();
      idle_pins();                                  // Inside reset
      wait (n_sys_reset18);
      idle_pins();                                  // Right after release
      step_cycle();
      compare("req_ready after reset", 32'(req_ready), 1);
   endtask

   task automatic word_bus32();
      bus_size = BSIZ_32;
      write_read(XSIZ_32, 32'h0000_0040, 0);
   endtask

   task automatic word_bus8();
      bus_size = BSIZ_8;
      write_read(XSIZ_32, 32'h0000_0084, 0);        // 11, 10, 01, 00
      write_read(XSIZ_16, 32'h0000_0092, 0);        // Upper half as x1 then x0
   endtask

   task automatic half_byte_mix();
      for (int b = 0; b < 2; b++)
      begin
         bus_size = (b == 0) ? BSIZ_16 : BSIZ_32;
         write_read(XSIZ_16, 32'h0000_00a0, 0);
         write_read(XSIZ_16, 32'h0000_00a6, 0);
         for (int a = 0; a < 4; a++)
            write_read(XSIZ_8, 32'h0000_00b0 + a, 0);
      end
   endtask

   task automatic resp_backpressure();
      int hold;
      bus_size = BSIZ_32;
      for (int t = 0; t < 4; t++)
      begin
         hold = 1 + ($random(seed) & 7);            // 1 to 8 stall cycles
         write_read((t < 2) ? XSIZ_32 : XSIZ_16, 32'h0000_00c0 + 4 * t, hold);
      end
   endtask

   initial
   begin
      bus_size   = BSIZ_32;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b0;
      reset_state();
      word_bus32();
      word_bus8();
      half_byte_mix();
      resp_backpressure();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
logic/smc_host_pkg.sv
logic/smc_emi_pkg.sv
logic/smc_access_ctrl.sv
logic/smc_addr.sv
logic/smc_data_lane.sv
logic/smc_lite.sv
dv/smc_clock_gen.sv
dv/smc_mem_model.sv
dv/smc_lite_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the smc_lite testbench with Verilator and runs it.
# The exit status is the simulation result.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module smc_lite_tb \
   -f files.f -Mdir obj_dir -o smc_lite_sim &&
./obj_dir/smc_lite_sim ||
{ echo "smc_lite simulation did not complete cleanly"; exit 1; }
